/* include/dcache_consts.svh */
// dcache memory geometry: ways, sets, line layout, widths and read port count
`ifndef DCACHE_CONSTS_SVH
`define DCACHE_CONSTS_SVH

// associativity
`define DCACHE_WAYS 2

// sets per way
`define DCACHE_SETS 16

// words per cacheline, one data bank per word offset
`define DCACHE_WORDS 4

// data word and tag widths
`define DCACHE_WORD_W 32
`define DCACHE_TAG_W 8

// number of read ports into the arbiter
`define DCACHE_PORTS 3

// derived address field widths
`define DCACHE_IDX_W 4
`define DCACHE_WOFF_W 2

// granted port number width
`define DCACHE_PSEL_W 2

`endif

/* verilog/dcache_pkg.sv */
// dcache memory types: request, write, bank command and lookup structs, arbiter modes
`default_nettype none

`include "dcache_consts.svh"

package dcache_pkg;

  // one read port's address
  typedef struct packed {
    logic [`DCACHE_IDX_W-1:0]  idx;
    logic [`DCACHE_WOFF_W-1:0] woff;
  } rd_req_t;

  // full cacheline refill
  typedef struct packed {
    logic                                    vld;
    logic [`DCACHE_WAYS-1:0]                 we;
    logic [`DCACHE_TAG_W-1:0]                tag;
    logic [`DCACHE_IDX_W-1:0]                idx;
    logic [`DCACHE_WORDS*`DCACHE_WORD_W-1:0] data;
    logic [`DCACHE_WORDS*`DCACHE_WORD_W/8-1:0] be;
    logic [`DCACHE_WAYS-1:0]                 vld_bits;
  } line_wr_t;

  // single word write, no tag access
  typedef struct packed {
    logic [`DCACHE_WAYS-1:0]     way_oh;
    logic [`DCACHE_IDX_W-1:0]    idx;
    logic [`DCACHE_WOFF_W-1:0]   woff;
    logic [`DCACHE_WORD_W-1:0]   data;
    logic [`DCACHE_WORD_W/8-1:0] be;
  } word_wr_t;

  // command to one data bank, all ways side by side
  typedef struct packed {
    logic                                             req;
    logic                                             we;
    logic [`DCACHE_IDX_W-1:0]                         idx;
    logic [`DCACHE_WAYS-1:0][`DCACHE_WORD_W/8-1:0]    be;
    logic [`DCACHE_WAYS-1:0][`DCACHE_WORD_W-1:0]      wdata;
  } bank_cmd_t;

  // handed from arbitration to the compare stage
  typedef struct packed {
    logic                      cmp_en;
    logic [`DCACHE_IDX_W-1:0]  idx;
    logic [`DCACHE_WOFF_W-1:0] woff;
    logic [`DCACHE_PSEL_W-1:0] psel;
  } lookup_t;

  // what the arbiter does in a cycle
  typedef enum logic [1:0] {
    ARB_IDLE,
    ARB_LINE_WRITE,
    ARB_READ,
    ARB_READ_WORD_WRITE
  } arb_mode_e;

endpackage

`default_nettype wire

/* verilog/dcache_port_arbiter.sv */
// dcache port arbiter: priority masking, round-robin read grant and bank commands
`default_nettype none

`include "dcache_consts.svh"

module dcache_port_arbiter (
  input  wire logic                                   clk_i,
  input  wire logic                                   rst_ni,
  input  wire logic [`DCACHE_PORTS-1:0]               rd_req_i,
  input  wire logic [`DCACHE_PORTS-1:0]               rd_prio_i,
  input  wire dcache_pkg::rd_req_t [`DCACHE_PORTS-1:0] rd_addr_i,
  input  wire dcache_pkg::line_wr_t                   line_wr_i,
  input  wire logic                                   word_wr_req_i,
  input  wire dcache_pkg::word_wr_t                   word_wr_i,
  output logic [`DCACHE_PORTS-1:0]                    rd_ack_o,
  output logic                                        word_wr_ack_o,
  output dcache_pkg::bank_cmd_t [`DCACHE_WORDS-1:0]   bank_cmd_o,
  output logic [`DCACHE_WAYS-1:0]                     tag_req_o,
  output logic                                        tag_we_o,
  output logic [`DCACHE_IDX_W-1:0]                    tag_idx_o,
  output dcache_pkg::lookup_t                         lookup_o
);

  logic [`DCACHE_PORTS-1:0]  prio_req;
  logic [`DCACHE_PORTS-1:0]  masked_req;
  logic [`DCACHE_PSEL_W-1:0] rr_q;
  logic [`DCACHE_PSEL_W-1:0] gnt_idx;
  logic                      found;
  logic                      rd_gnt;
  logic                      collision;
  dcache_pkg::rd_req_t       gnt_addr;
  dcache_pkg::arb_mode_e     mode;

  ////////////////////
  // read arbitration
  ////////////////////

  // high priority requesters shut out the low priority ones
  assign prio_req   = rd_req_i & rd_prio_i;
  assign masked_req = (|prio_req) ? prio_req : rd_req_i;

  // first competitor at or after the pointer, wrapping
  always_comb begin : p_rr_pick
    int p;
    found   = 1'b0;
    gnt_idx = '0;
    for (int i = 0; i < `DCACHE_PORTS; i++) begin
      p = (int'(rr_q) + i) % `DCACHE_PORTS;
      if (!found && masked_req[p]) begin
        found   = 1'b1;
        gnt_idx = `DCACHE_PSEL_W'(p);
      end
    end
  end

  // a refill takes the whole cycle
  assign rd_gnt   = found & ~line_wr_i.vld;
  assign rd_ack_o = rd_gnt ? (`DCACHE_PORTS'(1) << gnt_idx) : '0;
  assign gnt_addr = rd_addr_i[gnt_idx];

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_rr_ptr
    if (!rst_ni) begin
      rr_q <= '0;
    end else if (rd_gnt) begin
      rr_q <= `DCACHE_PSEL_W'((int'(gnt_idx) + 1) % `DCACHE_PORTS);
    end
  end

  // word write only loses to a refill or a read of the same bank
  assign collision     = rd_gnt & (gnt_addr.woff == word_wr_i.woff);
  assign word_wr_ack_o = word_wr_req_i & ~line_wr_i.vld & ~collision;

  always_comb begin : p_mode
    if (line_wr_i.vld) begin
      mode = dcache_pkg::ARB_LINE_WRITE;
    end else if (word_wr_ack_o) begin
      // word write, with or without a read beside it
      mode = dcache_pkg::ARB_READ_WORD_WRITE;
    end else if (rd_gnt) begin
      mode = dcache_pkg::ARB_READ;
    end else begin
      mode = dcache_pkg::ARB_IDLE;
    end
  end

  ////////////////////
  // bank commands
  ////////////////////

  always_comb begin : p_bank_cmd
    for (int k = 0; k < `DCACHE_WORDS; k++) begin
      bank_cmd_o[k].req   = 1'b0;
      bank_cmd_o[k].we    = 1'b0;
      bank_cmd_o[k].idx   = word_wr_i.idx;
      bank_cmd_o[k].be    = '0;
      bank_cmd_o[k].wdata = {`DCACHE_WAYS{word_wr_i.data}};
    end
    case (mode)
      dcache_pkg::ARB_LINE_WRITE: begin
        for (int k = 0; k < `DCACHE_WORDS; k++) begin
          bank_cmd_o[k].req = 1'b1;
          bank_cmd_o[k].we  = 1'b1;
          bank_cmd_o[k].idx = line_wr_i.idx;
          for (int j = 0; j < `DCACHE_WAYS; j++) begin
            bank_cmd_o[k].wdata[j] = line_wr_i.data[k*`DCACHE_WORD_W +: `DCACHE_WORD_W];
            if (line_wr_i.we[j]) begin
              bank_cmd_o[k].be[j] = line_wr_i.be[k*`DCACHE_WORD_W/8 +: `DCACHE_WORD_W/8];
            end
          end
        end
      end
      dcache_pkg::ARB_READ, dcache_pkg::ARB_READ_WORD_WRITE: begin
        if (rd_gnt) begin
          bank_cmd_o[gnt_addr.woff].req = 1'b1;
          bank_cmd_o[gnt_addr.woff].idx = gnt_addr.idx;
        end
        if (mode == dcache_pkg::ARB_READ_WORD_WRITE) begin
          bank_cmd_o[word_wr_i.woff].req = 1'b1;
          bank_cmd_o[word_wr_i.woff].we  = 1'b1;
          for (int j = 0; j < `DCACHE_WAYS; j++) begin
            if (word_wr_i.way_oh[j]) begin
              bank_cmd_o[word_wr_i.woff].be[j] = word_wr_i.be;
            end
          end
        end
      end
      default: ;
    endcase
  end

  // tags: refill writes the enabled ways, a read looks at all of them
  assign tag_we_o  = line_wr_i.vld;
  assign tag_idx_o = line_wr_i.vld ? line_wr_i.idx : gnt_addr.idx;
  assign tag_req_o = line_wr_i.vld ? line_wr_i.we : {`DCACHE_WAYS{rd_gnt}};

  assign lookup_o.cmp_en = rd_gnt;
  assign lookup_o.idx    = gnt_addr.idx;
  assign lookup_o.woff   = gnt_addr.woff;
  assign lookup_o.psel   = gnt_idx;

endmodule

`default_nettype wire

/* verilog/dcache_tag_array.sv */
// dcache tag array: per-way tags and reset-cleared valid bits with registered readout
`default_nettype none

`include "dcache_consts.svh"

module dcache_tag_array (
  input  wire logic                                      clk_i,
  input  wire logic                                      rst_ni,
  input  wire logic [`DCACHE_WAYS-1:0]                   tag_req_i,
  input  wire logic                                      tag_we_i,
  input  wire logic [`DCACHE_IDX_W-1:0]                  tag_idx_i,
  input  wire logic [`DCACHE_TAG_W-1:0]                  tag_i,
  input  wire logic [`DCACHE_WAYS-1:0]                   vld_bits_i,
  output logic [`DCACHE_WAYS-1:0][`DCACHE_TAG_W-1:0]     tag_rdata_o,
  output logic [`DCACHE_WAYS-1:0]                        vld_rdata_o
);

  logic [`DCACHE_WAYS-1:0][`DCACHE_TAG_W-1:0] tag_mem [`DCACHE_SETS];
  logic [`DCACHE_SETS-1:0][`DCACHE_WAYS-1:0]  vld_q;

  // tag storage and tag readout
  always_ff @(posedge clk_i) begin : p_tag_mem
    for (int j = 0; j < `DCACHE_WAYS; j++) begin
      if (tag_req_i[j]) begin
        if (tag_we_i) begin
          tag_mem[tag_idx_i][j] <= tag_i;
        end else begin
          tag_rdata_o[j] <= tag_mem[tag_idx_i][j];
        end
      end
    end
  end

  // valid flops, every line invalid out of reset
  always_ff @(posedge clk_i or negedge rst_ni) begin : p_vld
    if (!rst_ni) begin
      vld_q       <= '0;
      vld_rdata_o <= '0;
    end else begin
      for (int j = 0; j < `DCACHE_WAYS; j++) begin
        if (tag_req_i[j]) begin
          if (tag_we_i) begin
            vld_q[tag_idx_i][j] <= vld_bits_i[j];
          end else begin
            vld_rdata_o[j] <= vld_q[tag_idx_i][j];
          end
        end
      end
    end
  end

endmodule

`default_nettype wire

/* verilog/dcache_data_banks.sv */
// dcache data banks: one byte-enabled array per word offset holding all ways
`default_nettype none

`include "dcache_consts.svh"

module dcache_data_banks (
  input  wire logic                                      clk_i,
  input  wire dcache_pkg::bank_cmd_t [`DCACHE_WORDS-1:0] bank_cmd_i,
  output logic [`DCACHE_WORDS-1:0][`DCACHE_WAYS-1:0][`DCACHE_WORD_W-1:0] bank_rdata_o
);

  ////////////////////
  // banks
  ////////////////////

  // bank k holds word k of every line
  //   [way0 word k] [way1 word k] ...
  for (genvar k = 0; k < `DCACHE_WORDS; k++) begin : gen_bank
    logic [`DCACHE_WAYS-1:0][`DCACHE_WORD_W-1:0] mem [`DCACHE_SETS];
    dcache_pkg::bank_cmd_t                       cmd;

    assign cmd = bank_cmd_i[k];

    always_ff @(posedge clk_i) begin : p_bank
      if (cmd.req) begin
        if (cmd.we) begin
          // byte lanes per way, untouched lanes keep their data
          for (int j = 0; j < `DCACHE_WAYS; j++) begin
            for (int b = 0; b < `DCACHE_WORD_W/8; b++) begin
              if (cmd.be[j][b]) begin
                mem[cmd.idx][j][8*b +: 8] <= cmd.wdata[j][8*b +: 8];
              end
            end
          end
        end else begin
          bank_rdata_o[k] <= mem[cmd.idx];
        end
      end
    end
  end

endmodule

`default_nettype wire

/* verilog/dcache_hit_select.sv */
// dcache hit select: lookup stage register, late tag compare and hitting word readout
`default_nettype none

`include "dcache_consts.svh"

module dcache_hit_select (
  input  wire logic                                         clk_i,
  input  wire logic                                         rst_ni,
  input  wire dcache_pkg::lookup_t                          lookup_i,
  input  wire logic [`DCACHE_PORTS-1:0][`DCACHE_TAG_W-1:0]  rd_tag_i,
  input  wire logic [`DCACHE_WAYS-1:0][`DCACHE_TAG_W-1:0]   tag_rdata_i,
  input  wire logic [`DCACHE_WAYS-1:0]                      vld_rdata_i,
  input  wire logic [`DCACHE_WORDS-1:0][`DCACHE_WAYS-1:0][`DCACHE_WORD_W-1:0] bank_rdata_i,
  output logic [`DCACHE_WAYS-1:0]                           rd_hit_oh_o,
  output logic [`DCACHE_WAYS-1:0]                           rd_vld_bits_o,
  output logic [`DCACHE_WORD_W-1:0]                         rd_data_o
);

  dcache_pkg::lookup_t                         lookup_q;
  logic [`DCACHE_TAG_W-1:0]                    cmp_tag;
  logic [`DCACHE_WAYS-1:0][`DCACHE_WORD_W-1:0] way_word;

  // runs alongside the array read, both land in the same cycle
  always_ff @(posedge clk_i or negedge rst_ni) begin : p_lookup
    if (!rst_ni) begin
      lookup_q <= '0;
    end else begin
      lookup_q <= lookup_i;
    end
  end

  // tag of the granted port arrives one cycle after its request
  assign cmp_tag       = rd_tag_i[lookup_q.psel];
  assign rd_vld_bits_o = vld_rdata_i;
  assign way_word      = bank_rdata_i[lookup_q.woff];

  for (genvar j = 0; j < `DCACHE_WAYS; j++) begin : gen_cmp
    assign rd_hit_oh_o[j] = lookup_q.cmp_en & vld_rdata_i[j] & (tag_rdata_i[j] == cmp_tag);
  end

  // way 0 unless some other way hits
  always_comb begin : p_word_mux
    rd_data_o = way_word[0];
    for (int j = 1; j < `DCACHE_WAYS; j++) begin
      if (rd_hit_oh_o[j]) begin
        rd_data_o = way_word[j];
      end
    end
  end

endmodule

`default_nettype wire

/* verilog/dcache_mem.sv */
// dcache memory top: arbiter, tag array, data banks and hit select in two stages
`default_nettype none

`include "dcache_consts.svh"

module dcache_mem (
  input  wire logic                                        clk_i,
  input  wire logic                                        rst_ni,
  input  wire logic [`DCACHE_PORTS-1:0]                    rd_req_i,
  input  wire logic [`DCACHE_PORTS-1:0]                    rd_prio_i,
  input  wire dcache_pkg::rd_req_t [`DCACHE_PORTS-1:0]     rd_addr_i,
  input  wire logic [`DCACHE_PORTS-1:0][`DCACHE_TAG_W-1:0] rd_tag_i,
  output logic [`DCACHE_PORTS-1:0]                         rd_ack_o,
  output logic [`DCACHE_WAYS-1:0]                          rd_hit_oh_o,
  output logic [`DCACHE_WAYS-1:0]                          rd_vld_bits_o,
  output logic [`DCACHE_WORD_W-1:0]                        rd_data_o,
  input  wire dcache_pkg::line_wr_t                        line_wr_i,
  input  wire logic                                        word_wr_req_i,
  input  wire dcache_pkg::word_wr_t                        word_wr_i,
  output logic                                             word_wr_ack_o
);

  dcache_pkg::bank_cmd_t [`DCACHE_WORDS-1:0]                      bank_cmd;
  logic [`DCACHE_WORDS-1:0][`DCACHE_WAYS-1:0][`DCACHE_WORD_W-1:0] bank_rdata;
  logic [`DCACHE_WAYS-1:0]                                        tag_req;
  logic                                                           tag_we;
  logic [`DCACHE_IDX_W-1:0]                                       tag_idx;
  logic [`DCACHE_WAYS-1:0][`DCACHE_TAG_W-1:0]                     tag_rdata;
  logic [`DCACHE_WAYS-1:0]                                        vld_rdata;
  dcache_pkg::lookup_t                                            lookup;

  ////////////////////
  // stage 1
  ////////////////////

  dcache_port_arbiter i_arbiter (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .rd_req_i      (rd_req_i),
    .rd_prio_i     (rd_prio_i),
    .rd_addr_i     (rd_addr_i),
    .line_wr_i     (line_wr_i),
    .word_wr_req_i (word_wr_req_i),
    .word_wr_i     (word_wr_i),
    .rd_ack_o      (rd_ack_o),
    .word_wr_ack_o (word_wr_ack_o),
    .bank_cmd_o    (bank_cmd),
    .tag_req_o     (tag_req),
    .tag_we_o      (tag_we),
    .tag_idx_o     (tag_idx),
    .lookup_o      (lookup)
  );

  dcache_tag_array i_tag_array (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .tag_req_i   (tag_req),
    .tag_we_i    (tag_we),
    .tag_idx_i   (tag_idx),
    .tag_i       (line_wr_i.tag),
    .vld_bits_i  (line_wr_i.vld_bits),
    .tag_rdata_o (tag_rdata),
    .vld_rdata_o (vld_rdata)
  );

  dcache_data_banks i_data_banks (
    .clk_i        (clk_i),
    .bank_cmd_i   (bank_cmd),
    .bank_rdata_o (bank_rdata)
  );

  ////////////////////
  // stage 2
  ////////////////////

  dcache_hit_select i_hit_select (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .lookup_i      (lookup),
    .rd_tag_i      (rd_tag_i),
    .tag_rdata_i   (tag_rdata),
    .vld_rdata_i   (vld_rdata),
    .bank_rdata_i  (bank_rdata),
    .rd_hit_oh_o   (rd_hit_oh_o),
    .rd_vld_bits_o (rd_vld_bits_o),
    .rd_data_o     (rd_data_o)
  );

endmodule

`default_nettype wire

/* verification/dcache_mem_assertions.sv */
// dcache memory assertions: one-hot grant and hit, no word write beside a refill
`default_nettype none

`include "dcache_consts.svh"

module dcache_mem_assertions (
  input wire logic                      clk_i,
  input wire logic                      rst_ni,
  input wire logic [`DCACHE_PORTS-1:0]  rd_ack_i,
  input wire logic                      word_wr_ack_i,
  input wire logic                      line_wr_vld_i,
  input wire logic [`DCACHE_WAYS-1:0]   hit_oh_i
);

  // at most one read port wins a cycle
  a_ack_onehot : assert property (@(posedge clk_i) disable iff (!rst_ni) $onehot0(rd_ack_i))
    else $error("more than one read port acknowledged in one cycle");

  // tags in a set are unique, so at most one way can match
  a_hit_onehot : assert property (@(posedge clk_i) disable iff (!rst_ni) $onehot0(hit_oh_i))
    else $error("more than one way hit in one cycle");

  // refill owns every bank
  a_wack_no_line : assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(word_wr_ack_i && line_wr_vld_i))
    else $error("word write acknowledged during a line write");

endmodule

`default_nettype wire

/* verification/dcache_mem_tb.sv */
// dcache memory testbench: seeded random traffic checked against a reference model
`default_nettype none

`include "dcache_consts.svh"

module dcache_mem_tb;

  localparam int P       = `DCACHE_PORTS;
  localparam int WAYS    = `DCACHE_WAYS;
  localparam int WORD_W  = `DCACHE_WORD_W;
  localparam int LINE_BE = `DCACHE_WORDS*`DCACHE_WORD_W/8;
  localparam int WORD_BE = `DCACHE_WORD_W/8;
  localparam int IDLE    = 20;
  localparam int FILL    = `DCACHE_SETS*`DCACHE_WAYS;
  localparam int CYCLES  = 800;
  localparam int TIMEOUT = (CYCLES + 20) * 40 * 4;

  logic                                    clk_i;
  logic                                    rst_ni;
  logic [P-1:0]                            rd_req_i;
  logic [P-1:0]                            rd_prio_i;
  dcache_pkg::rd_req_t [P-1:0]             rd_addr_i;
  logic [P-1:0][`DCACHE_TAG_W-1:0]         rd_tag_i;
  logic [P-1:0]                            rd_ack_o;
  logic [WAYS-1:0]                         rd_hit_oh_o;
  logic [WAYS-1:0]                         rd_vld_bits_o;
  logic [WORD_W-1:0]                       rd_data_o;
  dcache_pkg::line_wr_t                    line_wr_i;
  logic                                    word_wr_req_i;
  dcache_pkg::word_wr_t                    word_wr_i;
  logic                                    word_wr_ack_o;

  // reference model state
  logic [`DCACHE_TAG_W-1:0] m_tag  [`DCACHE_SETS][WAYS];
  logic                     m_vld  [`DCACHE_SETS][WAYS];
  logic [WORD_W-1:0]        m_data [`DCACHE_SETS][WAYS][`DCACHE_WORDS];
  int                       rr;
  logic                     data_known;

  // read granted last cycle, with the array contents it saw
  logic                                 p_vld;
  logic                                 p_dchk;
  int                                   p_port;
  logic [WAYS-1:0]                      p_vbits;
  logic [WAYS-1:0][`DCACHE_TAG_W-1:0]   p_tags;
  logic [WAYS-1:0][WORD_W-1:0]          p_words;

  logic [`DCACHE_TAG_W-1:0] port_tag [P];
  logic [P-1:0]             seen_ack;
  logic                     seen_wack;
  int                       seed;
  int                       errors;

  dcache_mem DUT (.*);

  bind dcache_port_arbiter dcache_mem_assertions u_arb_chk (
    .clk_i(clk_i), .rst_ni(rst_ni), .rd_ack_i(rd_ack_o), .word_wr_ack_i(word_wr_ack_o),
    .line_wr_vld_i(line_wr_i.vld), .hit_oh_i('0)
  );
  bind dcache_hit_select dcache_mem_assertions u_hit_chk (
    .clk_i(clk_i), .rst_ni(rst_ni), .rd_ack_i('0), .word_wr_ack_i(1'b0),
    .line_wr_vld_i(1'b0), .hit_oh_i(rd_hit_oh_o)
  );

  always #20 clk_i = ~clk_i;

  function automatic int unsigned rand_below(input int unsigned n);
    rand_below = $unsigned($random(seed)) % n;
  endfunction

  task automatic expect_eq(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      errors++;
      $display("FAIL %s: got 0x%0h expected 0x%0h at time %0t", name, got, exp, $time);
      $display("Test failed");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  ////////////////////
  // stimulus
  ////////////////////

  task automatic drive_inputs(input int cyc);
    dcache_pkg::line_wr_t lw;
    dcache_pkg::word_wr_t ww;
    dcache_pkg::rd_req_t  ra;
    int                   w;
    lw = '0;
    if (cyc == IDLE + FILL) begin
      data_known = 1'b1;
    end
    // a port keeps its request until it is acknowledged
    for (int k = 0; k < P; k++) begin
      rd_tag_i[k] <= port_tag[k];
      if (!rd_req_i[k] || seen_ack[k]) begin
        ra.idx  = `DCACHE_IDX_W'(rand_below(`DCACHE_SETS));
        ra.woff = `DCACHE_WOFF_W'(rand_below(`DCACHE_WORDS));
        rd_addr_i[k] <= ra;
        rd_req_i[k]  <= (rand_below(3) != 0);
        rd_prio_i[k] <= (rand_below(4) == 0);
        if (data_known && rand_below(2) != 0) begin
          port_tag[k] = m_tag[ra.idx][rand_below(WAYS)];
        end else begin
          port_tag[k] = `DCACHE_TAG_W'(rand_below(2 * WAYS * 4));
        end
      end
    end
    // tag low bits carry the way, so a set never holds a tag twice
    if (cyc >= IDLE && cyc < IDLE + FILL) begin
      w           = (cyc - IDLE) % WAYS;
      lw.idx      = `DCACHE_IDX_W'((cyc - IDLE) / WAYS);
      lw.tag      = `DCACHE_TAG_W'(w);
      lw.be       = '1;
      lw.vld_bits = '0;
      lw.vld      = 1'b1;
    end else if (cyc >= IDLE + FILL && rand_below(8) == 0) begin
      w      = rand_below(WAYS);
      lw.idx = `DCACHE_IDX_W'(rand_below(`DCACHE_SETS));
      lw.tag = `DCACHE_TAG_W'(rand_below(4) * WAYS + w);
      lw.be  = (rand_below(2) != 0) ? '1 : LINE_BE'($random(seed));
      for (int j = 0; j < WAYS; j++) begin
        lw.vld_bits[j] = (rand_below(4) != 0);
      end
      lw.vld = 1'b1;
    end
    if (lw.vld) begin
      lw.we = WAYS'(1) << w;
      for (int k = 0; k < `DCACHE_WORDS; k++) begin
        lw.data[k*WORD_W +: WORD_W] = $random(seed);
      end
    end
    line_wr_i <= lw;
    if (cyc >= IDLE + FILL && (!word_wr_req_i || seen_wack)) begin
      ww.way_oh = WAYS'(1) << rand_below(WAYS);
      ww.idx    = `DCACHE_IDX_W'(rand_below(`DCACHE_SETS));
      ww.woff   = `DCACHE_WOFF_W'(rand_below(`DCACHE_WORDS));
      ww.data   = $random(seed);
      ww.be     = WORD_BE'(rand_below(1 << WORD_BE));
      word_wr_i     <= ww;
      word_wr_req_i <= (rand_below(2) == 0);
    end
  endtask

  ////////////////////
  // model and checks
  ////////////////////

  // results of the read granted one cycle earlier
  task automatic check_results();
    logic [WAYS-1:0]   hit;
    logic [WORD_W-1:0] word;
    hit  = '0;
    word = p_words[0];
    if (p_vld) begin
      for (int j = 0; j < WAYS; j++) begin
        hit[j] = p_vbits[j] && (p_tags[j] == rd_tag_i[p_port]);
        if (hit[j]) begin
          word = p_words[j];
        end
      end
    end
    expect_eq("rd_hit_oh_o", 64'(rd_hit_oh_o), 64'(hit));
    if (p_vld) begin
      expect_eq("rd_vld_bits_o", 64'(rd_vld_bits_o), 64'(p_vbits));
      if (p_dchk) begin
        expect_eq("rd_data_o", 64'(rd_data_o), 64'(word));
      end
    end
  endtask

  task automatic update_model();
    logic [P-1:0]        comp;
    logic [P-1:0]        ack;
    logic                wack;
    logic                got;
    int                  g;
    int                  p;
    dcache_pkg::rd_req_t ga;
    ack  = '0;
    wack = 1'b0;
    got  = 1'b0;
    g    = 0;
    if (!line_wr_i.vld) begin
      comp = ((rd_req_i & rd_prio_i) != '0) ? (rd_req_i & rd_prio_i) : rd_req_i;
      for (int i = 0; i < P; i++) begin
        p = (rr + i) % P;
        if (!got && comp[p]) begin
          got = 1'b1;
          g   = p;
        end
      end
      ack[g] = got;
      wack   = word_wr_req_i && !(got && rd_addr_i[g].woff == word_wr_i.woff);
    end
    expect_eq("rd_ack_o", 64'(rd_ack_o), 64'(ack));
    expect_eq("word_wr_ack_o", 64'(word_wr_ack_o), 64'(wack));
    seen_ack  = ack;
    seen_wack = wack;
    // snapshot before this cycle's writes land
    ga     = rd_addr_i[g];
    p_vld  = got;
    p_dchk = data_known;
    p_port = g;
    for (int j = 0; j < WAYS; j++) begin
      p_vbits[j] = m_vld[ga.idx][j];
      p_tags[j]  = m_tag[ga.idx][j];
      p_words[j] = m_data[ga.idx][j][ga.woff];
    end
    for (int j = 0; j < WAYS; j++) begin
      if (line_wr_i.vld && line_wr_i.we[j]) begin
        m_tag[line_wr_i.idx][j] = line_wr_i.tag;
        m_vld[line_wr_i.idx][j] = line_wr_i.vld_bits[j];
        for (int b = 0; b < LINE_BE; b++) begin
          if (line_wr_i.be[b]) begin
            m_data[line_wr_i.idx][j][b/WORD_BE][8*(b%WORD_BE) +: 8] = line_wr_i.data[8*b +: 8];
          end
        end
      end
      if (wack && word_wr_i.way_oh[j]) begin
        for (int b = 0; b < WORD_BE; b++) begin
          if (word_wr_i.be[b]) begin
            m_data[word_wr_i.idx][j][word_wr_i.woff][8*b +: 8] = word_wr_i.data[8*b +: 8];
          end
        end
      end
    end
    if (got) begin
      rr = (g + 1) % P;
    end
  endtask

  // outputs are settled by the falling edge
  always @(negedge clk_i) begin
    if (rst_ni) begin
      check_results();
      update_model();
    end
  end

  initial begin
    #(TIMEOUT);
    $display("Timeout: the run did not finish within its cycle budget");
    $display("Test failed");
    $fatal(1, "watchdog expired");
  end

  initial begin
    seed          = 32'he919117e;
    errors        = 0;
    clk_i         = 1'b0;
    rst_ni        = 1'b0;
    rd_req_i      = '0;
    rd_prio_i     = '0;
    rd_addr_i     = '0;
    rd_tag_i      = '0;
    line_wr_i     = '0;
    word_wr_req_i = 1'b0;
    word_wr_i     = '0;
    rr            = 0;
    data_known    = 1'b0;
    p_vld         = 1'b0;
    seen_ack      = '0;
    seen_wack     = 1'b0;
    for (int s = 0; s < `DCACHE_SETS; s++) begin
      for (int j = 0; j < WAYS; j++) begin
        m_tag[s][j] = '0;
        m_vld[s][j] = 1'b0;
      end
    end
    for (int k = 0; k < P; k++) begin
      port_tag[k] = '0;
    end
    repeat (5) @(posedge clk_i);
    rst_ni <= 1'b1;
    // idle reads, then fill every way invalid, then mixed traffic
    for (int cyc = 0; cyc < CYCLES; cyc++) begin
      @(posedge clk_i);
      drive_inputs(cyc);
    end
    @(posedge clk_i);
    rd_req_i      <= '0;
    word_wr_req_i <= 1'b0;
    line_wr_i     <= '0;
    repeat (3) @(posedge clk_i);
    if (errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* dcache_mem.f */
+incdir+include
verilog/dcache_pkg.sv
verilog/dcache_port_arbiter.sv
verilog/dcache_tag_array.sv
verilog/dcache_data_banks.sv
verilog/dcache_hit_select.sv
verilog/dcache_mem.sv
verification/dcache_mem_assertions.sv
verification/dcache_mem_tb.sv

/* Makefile */
TOP = dcache_mem_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f dcache_mem.f \
		--top-module $(TOP) -o $(TOP)

run: compile
	@out=$$(./obj_dir/$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "Test completed successfully"

clean:
	rm -rf obj_dir
